// File: backend_pkg.sv
package backend_pkg;

    // ------------------------------
    // machine sizes
    // ------------------------------
    localparam int NUM_ARCH    = 8;
    localparam int NUM_PREG    = 16;
    localparam int FREE_DEPTH  = NUM_PREG - NUM_ARCH;
    localparam int TIMER_SLOTS = 4;
    localparam int LAT_W       = 3;
    localparam int TAG_W       = 8;

    localparam int AREG_W      = $clog2(NUM_ARCH);
    localparam int PREG_W      = $clog2(NUM_PREG);
    localparam int SLOT_W      = $clog2(TIMER_SLOTS);
    localparam int FREE_PTR_W  = $clog2(FREE_DEPTH);
    localparam int FREE_CNT_W  = $clog2(FREE_DEPTH + 1);
    // one release per timer slot plus the walk.
    localparam int NUM_RELEASE = TIMER_SLOTS + 1;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [LAT_W-1:0]  lat_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // ------------------------------
    // op formats
    // ------------------------------
    typedef struct packed {
        tag_t  tag;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        lat_t  lat;
    } arch_op_t;

    typedef struct packed {
        tag_t  tag;
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
        areg_t rd;
        lat_t  lat;
    } renamed_op_t;

    typedef struct packed {
        tag_t  tag;
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        lat_t  lat;
    } issue_op_t;

    typedef struct packed {
        preg_t prd;
        preg_t old_prd;
    } wakeup_t;

    typedef enum logic {
        RUN,
        WALK
    } issue_state_t;

endpackage

// File: rename_map.sv
`timescale 1ns/1ps

module rename_map (
    input  logic                     clk,
    input  logic                     rst,
    input  backend_pkg::areg_t       rs1,
    input  backend_pkg::areg_t       rs2,
    input  backend_pkg::areg_t       rd,
    output backend_pkg::preg_t       prs1,
    output backend_pkg::preg_t       prs2,
    output backend_pkg::preg_t       old_prd,
    input  logic                     rename_en,
    input  backend_pkg::preg_t       rename_prd,
    input  logic                     walk_en,
    input  backend_pkg::renamed_op_t walk_op
);
    import backend_pkg::*;

    preg_t map_table [NUM_ARCH];

    // source and previous destination lookups.
    assign prs1    = map_table[rs1];
    assign prs2    = map_table[rs2];
    assign old_prd = map_table[rd];

    // ------------------------------
    // table update
    // ------------------------------
    // the walk only happens while no op is being accepted.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_table[i] <= preg_t'(i);
            end
        end else if (walk_en) begin
            map_table[walk_op.rd] <= walk_op.old_prd;
        end else if (rename_en) begin
            map_table[rd] <= rename_prd;
        end
    end

endmodule

// File: free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                pop,
    output backend_pkg::preg_t                  head,
    output logic                                empty,
    input  logic [backend_pkg::TIMER_SLOTS-1:0] wakeup_en,
    input  backend_pkg::wakeup_t                wakeup [backend_pkg::TIMER_SLOTS],
    input  logic                                walk_en,
    input  backend_pkg::preg_t                  walk_prd
);
    import backend_pkg::*;

    preg_t                  entries [FREE_DEPTH];
    logic [FREE_PTR_W-1:0]  rd_ptr;
    logic [FREE_PTR_W-1:0]  wr_ptr;
    logic [FREE_CNT_W-1:0]  count;

    logic                   rel_en   [NUM_RELEASE];
    preg_t                  rel_prd  [NUM_RELEASE];
    logic [FREE_PTR_W-1:0]  push_ptr [NUM_RELEASE];
    logic [FREE_CNT_W-1:0]  push_cnt;

    assign head  = entries[rd_ptr];
    assign empty = (count == '0);

    // ------------------------------
    // release compaction
    // ------------------------------
    // timer slots first in slot order, walk last.
    always_comb begin
        for (int i = 0; i < TIMER_SLOTS; i++) begin
            rel_en[i]  = wakeup_en[i];
            rel_prd[i] = wakeup[i].old_prd;
        end
        rel_en[TIMER_SLOTS]  = walk_en;
        rel_prd[TIMER_SLOTS] = walk_prd;

        push_cnt = '0;
        for (int i = 0; i < NUM_RELEASE; i++) begin
            push_ptr[i] = wr_ptr + push_cnt[FREE_PTR_W-1:0];
            if (rel_en[i]) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    // the queue starts full with the registers above the identity map.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= FREE_CNT_W'(FREE_DEPTH);
            for (int i = 0; i < FREE_DEPTH; i++) begin
                entries[i] <= preg_t'(NUM_ARCH + i);
            end
        end else begin
            for (int i = 0; i < NUM_RELEASE; i++) begin
                if (rel_en[i]) begin
                    entries[push_ptr[i]] <= rel_prd[i];
                end
            end
            rd_ptr <= rd_ptr + FREE_PTR_W'(pop);
            wr_ptr <= wr_ptr + push_cnt[FREE_PTR_W-1:0];
            count  <= count + push_cnt - FREE_CNT_W'(pop);
        end
    end

endmodule

// File: busy_table.sv
`timescale 1ns/1ps

module busy_table (
    input  logic                                clk,
    input  logic                                rst,
    input  backend_pkg::preg_t                  prs1,
    input  backend_pkg::preg_t                  prs2,
    output logic                                src1_ready,
    output logic                                src2_ready,
    input  logic                                alloc_en,
    input  backend_pkg::preg_t                  alloc_prd,
    input  logic [backend_pkg::TIMER_SLOTS-1:0] wakeup_en,
    input  backend_pkg::wakeup_t                wakeup [backend_pkg::TIMER_SLOTS],
    input  logic                                walk_en,
    input  backend_pkg::preg_t                  walk_prd
);
    import backend_pkg::*;

    logic [NUM_PREG-1:0] ready;
    logic [NUM_PREG-1:0] wb_set;
    logic [NUM_PREG-1:0] walk_set;
    logic [NUM_PREG-1:0] alloc_clr;
    logic [NUM_PREG-1:0] ready_bypass;

    // ------------------------------
    // set and clear vectors
    // ------------------------------
    always_comb begin
        wb_set = '0;
        for (int i = 0; i < TIMER_SLOTS; i++) begin
            if (wakeup_en[i]) begin
                wb_set[wakeup[i].prd] = 1'b1;
            end
        end
    end

    assign walk_set  = walk_en ? (NUM_PREG'(1) << walk_prd) : '0;
    assign alloc_clr = alloc_en ? (NUM_PREG'(1) << alloc_prd) : '0;

    // wakeups in this cycle count as ready already.
    assign ready_bypass = ready | wb_set;
    assign src1_ready   = ready_bypass[prs1];
    assign src2_ready   = ready_bypass[prs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready <= '1;
        end else begin
            ready <= (ready_bypass | walk_set) & ~alloc_clr;
        end
    end

endmodule

// File: exec_timer.sv
`timescale 1ns/1ps

module exec_timer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  backend_pkg::issue_op_t              start_op,
    input  backend_pkg::preg_t                  old_prd,
    output logic                                slot_free,
    output logic [backend_pkg::TIMER_SLOTS-1:0] wakeup_en,
    output backend_pkg::wakeup_t                wakeup [backend_pkg::TIMER_SLOTS]
);
    import backend_pkg::*;

    logic [TIMER_SLOTS-1:0] busy;
    lat_t                   cnt     [TIMER_SLOTS];
    wakeup_t                slot_wk [TIMER_SLOTS];

    logic [SLOT_W-1:0]      free_idx;
    logic [TIMER_SLOTS-1:0] load;
    logic [TIMER_SLOTS-1:0] fire;

    // ------------------------------
    // slot allocation
    // ------------------------------
    // lowest idle slot wins; a firing slot is still busy here.
    always_comb begin
        free_idx  = '0;
        slot_free = 1'b0;
        for (int i = TIMER_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx  = SLOT_W'(i);
                slot_free = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < TIMER_SLOTS; i++) begin : g_slot
        assign load[i]      = start & slot_free & (free_idx == SLOT_W'(i));
        assign fire[i]      = busy[i] & (cnt[i] == '0);
        assign wakeup_en[i] = fire[i];
        assign wakeup[i]    = slot_wk[i];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                busy[i] <= 1'b0;
            end else if (load[i]) begin
                busy[i] <= 1'b1;
            end else if (fire[i]) begin
                busy[i] <= 1'b0;
            end
        end

        // counter starts at lat-1 so it reaches zero lat edges after the load.
        always_ff @(posedge clk) begin
            if (load[i]) begin
                cnt[i]             <= start_op.lat - lat_t'(1);
                slot_wk[i].prd     <= start_op.prd;
                slot_wk[i].old_prd <= old_prd;
            end else if (busy[i] && !fire[i]) begin
                cnt[i] <= cnt[i] - lat_t'(1);
            end
        end
    end

endmodule

// File: issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  backend_pkg::arch_op_t    in_op,
    output logic                     in_ready,
    output logic                     issue_valid,
    output backend_pkg::issue_op_t   issue_op,
    input  logic                     issue_ready,
    output logic                     rename_en,
    input  backend_pkg::preg_t       prs1,
    input  backend_pkg::preg_t       prs2,
    input  backend_pkg::preg_t       old_prd,
    input  backend_pkg::preg_t       free_head,
    input  logic                     free_empty,
    input  logic                     src1_ready,
    input  logic                     src2_ready,
    input  logic                     slot_free,
    output logic                     timer_start,
    output logic                     walk_en,
    output backend_pkg::renamed_op_t walk_op
);
    import backend_pkg::*;

    issue_state_t state;
    logic         slot_valid;
    renamed_op_t  slot_op;

    logic         issue_fire;
    logic         accept;
    logic         drop;

    // ------------------------------
    // handshakes
    // ------------------------------
    assign issue_valid = slot_valid & src1_ready & src2_ready & slot_free;
    assign issue_fire  = issue_valid & issue_ready;

    assign in_ready = (state == RUN) & ~flush & ~free_empty & (~slot_valid | issue_fire);
    assign accept   = in_valid & in_ready;

    // an op that issues at the flush edge is kept.
    assign drop = flush & slot_valid & ~issue_fire;

    assign rename_en   = accept;
    assign timer_start = issue_fire;

    always_comb begin
        issue_op.tag  = slot_op.tag;
        issue_op.prs1 = slot_op.prs1;
        issue_op.prs2 = slot_op.prs2;
        issue_op.prd  = slot_op.prd;
        issue_op.lat  = slot_op.lat;
    end

    // the dropped op stays in slot_op during the walk cycle.
    assign walk_en = (state == WALK);
    assign walk_op = slot_op;

    // ------------------------------
    // state and slot control
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RUN;
            slot_valid <= 1'b0;
        end else begin
            case (state)
                RUN: begin
                    if (drop) begin
                        state <= WALK;
                    end
                end
                WALK: state <= RUN;
                default: state <= RUN;
            endcase

            if (accept) begin
                slot_valid <= 1'b1;
            end else if (issue_fire || drop) begin
                slot_valid <= 1'b0;
            end
        end
    end

    // renamed op captured at the accept edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_op.tag     <= in_op.tag;
            slot_op.prs1    <= prs1;
            slot_op.prs2    <= prs2;
            slot_op.prd     <= free_head;
            slot_op.old_prd <= old_prd;
            slot_op.rd      <= in_op.rd;
            slot_op.lat     <= in_op.lat;
        end
    end

endmodule

// File: rename_core.sv
`timescale 1ns/1ps

module rename_core (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                in_valid,
    input  backend_pkg::arch_op_t               in_op,
    output logic                                in_ready,
    output logic                                issue_valid,
    output backend_pkg::issue_op_t              issue_op,
    input  logic                                issue_ready,
    output logic [backend_pkg::TIMER_SLOTS-1:0] wakeup_en,
    output backend_pkg::wakeup_t                wakeup [backend_pkg::TIMER_SLOTS]
);
    import backend_pkg::*;

    preg_t       prs1;
    preg_t       prs2;
    preg_t       old_prd;
    logic        rename_en;
    preg_t       free_head;
    logic        free_empty;
    logic        src1_ready;
    logic        src2_ready;
    logic        slot_free;
    logic        timer_start;
    logic        walk_en;
    renamed_op_t walk_op;

    // ------------------------------
    // rename stage
    // ------------------------------
    rename_map i_map (
        .clk        (clk),
        .rst        (rst),
        .rs1        (in_op.rs1),
        .rs2        (in_op.rs2),
        .rd         (in_op.rd),
        .prs1       (prs1),
        .prs2       (prs2),
        .old_prd    (old_prd),
        .rename_en  (rename_en),
        .rename_prd (free_head),
        .walk_en    (walk_en),
        .walk_op    (walk_op)
    );

    free_list i_free (
        .clk       (clk),
        .rst       (rst),
        .pop       (rename_en),
        .head      (free_head),
        .empty     (free_empty),
        .wakeup_en (wakeup_en),
        .wakeup    (wakeup),
        .walk_en   (walk_en),
        .walk_prd  (walk_op.prd)
    );

    // sources are looked up for the op held in the issue slot.
    busy_table i_busy (
        .clk        (clk),
        .rst        (rst),
        .prs1       (issue_op.prs1),
        .prs2       (issue_op.prs2),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready),
        .alloc_en   (rename_en),
        .alloc_prd  (free_head),
        .wakeup_en  (wakeup_en),
        .wakeup     (wakeup),
        .walk_en    (walk_en),
        .walk_prd   (walk_op.prd)
    );

    // ------------------------------
    // issue and timing
    // ------------------------------
    issue_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .rename_en   (rename_en),
        .prs1        (prs1),
        .prs2        (prs2),
        .old_prd     (old_prd),
        .free_head   (free_head),
        .free_empty  (free_empty),
        .src1_ready  (src1_ready),
        .src2_ready  (src2_ready),
        .slot_free   (slot_free),
        .timer_start (timer_start),
        .walk_en     (walk_en),
        .walk_op     (walk_op)
    );

    // walk_op mirrors the issue slot, so it also carries old_prd at issue.
    exec_timer i_timer (
        .clk       (clk),
        .rst       (rst),
        .start     (timer_start),
        .start_op  (issue_op),
        .old_prd   (walk_op.old_prd),
        .slot_free (slot_free),
        .wakeup_en (wakeup_en),
        .wakeup    (wakeup)
    );

endmodule

// File: tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core;
    import backend_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   flush;
    logic                   in_valid;
    arch_op_t               in_op;
    logic                   in_ready;
    logic                   issue_valid;
    issue_op_t              issue_op;
    logic                   issue_ready;
    logic [TIMER_SLOTS-1:0] wakeup_en;
    wakeup_t                wakeup [TIMER_SLOTS];

    integer                 seed;
    int                     errors;
    int                     checks;
    int                     issued;
    int                     cyc;
    tag_t                   next_tag;
    logic                   mon_on;
    logic                   took;

    // reference model state.
    preg_t                  map_m [NUM_ARCH];
    logic [NUM_PREG-1:0]    rdy_m;
    logic [NUM_PREG-1:0]    live_m;
    preg_t                  free_q [$];
    logic                   pend;
    renamed_op_t            pend_op;
    logic                   walk_m;
    preg_t                  walk_prd_m;
    logic [TIMER_SLOTS-1:0] slot_busy;
    int                     slot_due [TIMER_SLOTS];
    wakeup_t                slot_wk  [TIMER_SLOTS];

    rename_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .wakeup_en   (wakeup_en),
        .wakeup      (wakeup)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic model_reset();
        live_m = '0;
        for (int i = 0; i < NUM_ARCH; i++) begin
            map_m[i]  = preg_t'(i);
            live_m[i] = 1'b1;
        end
        free_q.delete();
        for (int i = 0; i < FREE_DEPTH; i++) begin
            free_q.push_back(preg_t'(NUM_ARCH + i));
        end
        rdy_m     = '1;
        pend      = 1'b0;
        walk_m    = 1'b0;
        slot_busy = '0;
        cyc       = 0;
    endtask

    // ------------------------------
    // reference scoreboard
    // ------------------------------
    always @(posedge clk) begin : monitor
        logic [NUM_PREG-1:0]    rdy_byp;
        logic [TIMER_SLOTS-1:0] fire_m;
        logic                   exp_valid;
        logic                   exp_fire;
        logic                   exp_in_ready;
        logic                   acc;
        logic                   drop;
        int                     idle;
        issue_op_t              exp_op;
        if (mon_on) begin
            cyc++;
            // ops due this cycle count as ready for the waiting op.
            rdy_byp = rdy_m;
            idle    = -1;
            for (int i = TIMER_SLOTS - 1; i >= 0; i--) begin
                fire_m[i] = slot_busy[i] && (slot_due[i] == cyc);
                if (fire_m[i]) begin
                    rdy_byp[slot_wk[i].prd] = 1'b1;
                end
                if (!slot_busy[i]) begin
                    idle = i;
                end
            end
            exp_valid = pend && rdy_byp[pend_op.prs1] && rdy_byp[pend_op.prs2]
                        && (idle >= 0);
            exp_fire     = exp_valid && issue_ready;
            exp_in_ready = !walk_m && !flush && (free_q.size() > 0) && (!pend || exp_fire);
            acc          = in_valid && exp_in_ready;
            drop         = flush && pend && !exp_fire;
            check_val("issue_valid", issue_valid, exp_valid);
            check_val("in_ready", in_ready, exp_in_ready);
            if (exp_valid) begin
                exp_op.tag  = pend_op.tag;
                exp_op.prs1 = pend_op.prs1;
                exp_op.prs2 = pend_op.prs2;
                exp_op.prd  = pend_op.prd;
                exp_op.lat  = pend_op.lat;
                check_val("issue_op", issue_op, exp_op);
            end
            for (int i = 0; i < TIMER_SLOTS; i++) begin
                check_val($sformatf("wakeup_en[%0d]", i), wakeup_en[i], fire_m[i]);
                if (fire_m[i]) begin
                    check_val($sformatf("wakeup[%0d]", i), wakeup[i], slot_wk[i]);
                end
            end
            if (exp_fire) begin
                check_val("prd live at issue", live_m[issue_op.prd], 1'b0);
                check_val("sources ready at issue",
                          rdy_byp[issue_op.prs1] && rdy_byp[issue_op.prs2], 1'b1);
                map_m[pend_op.rd]     = pend_op.prd;
                live_m[issue_op.prd]  = 1'b1;
                slot_busy[idle]       = 1'b1;
                slot_due[idle]        = cyc + int'(pend_op.lat);
                slot_wk[idle].prd     = pend_op.prd;
                slot_wk[idle].old_prd = pend_op.old_prd;
                pend                  = 1'b0;
                issued++;
            end
            // releases go back to the pool in slot order, walk last.
            for (int i = 0; i < TIMER_SLOTS; i++) begin
                if (wakeup_en[i]) begin
                    live_m[wakeup[i].old_prd] = 1'b0;
                end
                if (fire_m[i]) begin
                    slot_busy[i]          = 1'b0;
                    rdy_m[slot_wk[i].prd] = 1'b1;
                    free_q.push_back(slot_wk[i].old_prd);
                end
            end
            if (walk_m) begin
                rdy_m[walk_prd_m] = 1'b1;
                free_q.push_back(walk_prd_m);
                walk_m = 1'b0;
            end
            if (drop) begin
                walk_m     = 1'b1;
                walk_prd_m = pend_op.prd;
                pend       = 1'b0;
            end
            if (acc) begin
                pend_op.tag        = in_op.tag;
                pend_op.prs1       = map_m[in_op.rs1];
                pend_op.prs2       = map_m[in_op.rs2];
                pend_op.old_prd    = map_m[in_op.rd];
                pend_op.prd        = free_q.pop_front();
                pend_op.rd         = in_op.rd;
                pend_op.lat        = in_op.lat;
                rdy_m[pend_op.prd] = 1'b0;
                pend               = 1'b1;
            end
            took = acc;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    // a pending op is held until it is taken.
    task automatic drive_cycle(input bit flush_on, input bit bp_on);
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        if (!in_valid || took) begin
            in_valid  = r[0];
            in_op.tag = next_tag;
            in_op.rs1 = r[10:8];
            in_op.rs2 = r[13:11];
            in_op.rd  = r[16:14];
            in_op.lat = (r[19:17] == 3'd0) ? 3'd1 : r[19:17];
            next_tag  = next_tag + 1'b1;
        end
        issue_ready = bp_on ? (r[3:2] != 2'b00) : 1'b1;
        flush       = flush_on && (r[7:4] == 4'd0);
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("test %s finished, %0d errors", name, errors - err_start);
    endtask

    task automatic run_stream(input string name, input int cycles, input bit flush_on);
        int err_start;
        int issued_start;
        err_start    = errors;
        issued_start = issued;
        repeat (cycles) begin
            drive_cycle(flush_on, 1'b1);
        end
        if (issued == issued_start) begin
            $display("no op was issued during test %s", name);
            errors++;
        end
        finish_test(name, err_start);
    endtask

    task automatic reset_test();
        int err_start;
        int issued_start;
        int n;
        err_start = errors;
        check_val("issue_valid", issue_valid, 1'b0);
        check_val("wakeup_en", wakeup_en, '0);
        n = 0;
        while (!in_ready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("in_ready did not rise within 16 cycles after reset");
            errors++;
        end
        issued_start = issued;
        repeat (24) begin
            drive_cycle(1'b0, 1'b0);
        end
        if (issued == issued_start) begin
            $display("no op was issued after reset");
            errors++;
        end
        finish_test("reset", err_start);
    endtask

    task automatic drain_test();
        int err_start;
        int n;
        err_start = errors;
        @(negedge clk);
        in_valid    = 1'b0;
        flush       = 1'b0;
        issue_ready = 1'b1;
        n = 0;
        while ((pend || walk_m || slot_busy != '0 || issue_valid) && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (pend || walk_m || slot_busy != '0) begin
            $display("the pipeline did not drain within 64 cycles");
            errors++;
        end
        check_val("free register count", free_q.size(), NUM_PREG - $countones(live_m));
        check_val("live register count", $countones(live_m), NUM_ARCH);
        check_val("in_ready when idle", in_ready, 1'b1);
        finish_test("drain", err_start);
    endtask

    initial begin
        seed        = 32'h8cad;
        errors      = 0;
        checks      = 0;
        issued      = 0;
        next_tag    = '0;
        mon_on      = 1'b0;
        took        = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_op       = '0;
        issue_ready = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst    = 1'b0;
        mon_on = 1'b1;
        reset_test();
        run_stream("rename", 600, 1'b0);
        run_stream("flush", 1500, 1'b1);
        drain_test();
        $display("tests 4, issued %0d, checks %0d, errors %0d", issued, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
backend_pkg.sv
rename_map.sv
free_list.sv
busy_table.sv
exec_timer.sv
issue_ctrl.sv
rename_core.sv
tb_rename_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rename_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
